// File: design/rename_config.svh
////////////////////////////////////////
// sizes for the rename stage, include before rename_pkg
// or any module that needs a width
////////////////////////////////////////

`ifndef RENAME_CONFIG_SVH
`define RENAME_CONFIG_SVH

// architectural registers, reg 0 is hard zero
`define ARCH_REGS    8
`define ARCH_LEN     3

// physical registers
`define PRF_SIZE     16
`define PRF_LEN      4

`define XLEN         32   // data word
`define RETIRE_DEPTH 8    // in-flight renamed instructions

`endif

// File: design/rename_pkg.sv
////////////////////////////////////////
// shared types of the rename stage
////////////////////////////////////////

`include "rename_config.svh"

package rename_pkg;

    // register indices
    typedef logic [`ARCH_LEN-1:0] arch_idx_t;
    typedef logic [`PRF_LEN-1:0]  preg_idx_t;

    // data value
    typedef logic [`XLEN-1:0] word_t;

    // one preg per architectural register
    typedef preg_idx_t [`ARCH_REGS-1:0] map_t;

    // circular free list storage, one slot per preg
    typedef preg_idx_t [`PRF_SIZE-1:0] free_list_t;

    // one bit per physical register
    typedef logic [`PRF_SIZE-1:0] prf_mask_t;

    // number of free pregs, 0 to PRF_SIZE
    typedef logic [`PRF_LEN:0] free_cnt_t;

endpackage

// File: design/map_table.sv
////////////////////////////////////////
// speculative rename map, renames the destination and
// looks up both sources of the dispatched instruction
////////////////////////////////////////

`timescale 1ns/1ps

`include "rename_config.svh"

module map_table
    import rename_pkg::*;
(
    input  logic      clock,
    input  logic      reset,
    input  logic      dispatch_enable,   // already qualified by dispatch_ready
    input  logic      dest_valid,
    input  logic      commit_mis_pred,
    input  arch_idx_t dest_arch,
    input  arch_idx_t src_a_arch,
    input  arch_idx_t src_b_arch,
    input  preg_idx_t new_preg,          // free list head
    input  map_t      committed_map,     // from retire map
    output preg_idx_t opa_preg,
    output preg_idx_t opb_preg,
    output preg_idx_t prev_preg,
    output logic      renamed
);

    map_t spec_map;

    ////////////////////////////////////////
    // lookup
    ////////////////////////////////////////

    // sources see the map before this instruction's own rename
    assign opa_preg  = spec_map[src_a_arch];
    assign opb_preg  = spec_map[src_b_arch];

    // old home of the destination, freed when this instruction commits
    assign prev_preg = spec_map[dest_arch];

    // arch reg 0 never leaves preg 0
    assign renamed   = dispatch_enable && dest_valid && (dest_arch != '0);

    ////////////////////////////////////////
    // update
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            // identity map, arch i lives in preg i
            for (int i = 0; i < `ARCH_REGS; i++) begin
                spec_map[i] <= preg_idx_t'(i);
            end
        end else if (commit_mis_pred) begin
            spec_map <= committed_map;           // drop all speculative renames
        end else if (renamed) begin
            spec_map[dest_arch] <= new_preg;
        end
    end

endmodule

// File: design/prf.sv
////////////////////////////////////////
// physical register file with ready bits, result bypass
// and the circular free list of physical registers
////////////////////////////////////////

`timescale 1ns/1ps

`include "rename_config.svh"

module prf
    import rename_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  preg_idx_t  opa_preg,
    input  preg_idx_t  opb_preg,
    input  logic       alloc,              // pop free list head
    input  logic       free_valid,         // push free_preg at tail
    input  preg_idx_t  free_preg,
    input  logic       cdb_valid,
    input  preg_idx_t  cdb_preg,
    input  word_t      cdb_result,
    input  logic       commit_mis_pred,
    input  prf_mask_t  valid_backup,       // recovery state from retire map
    input  free_list_t free_queue_backup,
    input  preg_idx_t  free_head_backup,
    input  preg_idx_t  free_tail_backup,
    output preg_idx_t  new_preg,
    output free_cnt_t  free_count,
    output logic       opa_ready,
    output word_t      opa_value,
    output logic       opb_ready,
    output word_t      opb_value
);

    word_t      values [`PRF_SIZE];
    prf_mask_t  ready;
    free_list_t free_queue;
    preg_idx_t  free_head;
    preg_idx_t  free_tail;
    logic       cdb_write;
    logic       hit_a;
    logic       hit_b;
    logic       push;

    ////////////////////////////////////////
    // operand read with bypass
    ////////////////////////////////////////

    assign cdb_write = cdb_valid && (cdb_preg != '0);   // preg 0 stays zero
    assign hit_a     = cdb_write && (cdb_preg == opa_preg);
    assign hit_b     = cdb_write && (cdb_preg == opb_preg);

    assign opa_value = hit_a ? cdb_result : values[opa_preg];
    assign opb_value = hit_b ? cdb_result : values[opb_preg];
    assign opa_ready = hit_a || ready[opa_preg];
    assign opb_ready = hit_b || ready[opb_preg];

    assign new_preg  = free_queue[free_head];
    assign push      = free_valid && (free_preg != '0);

    ////////////////////////////////////////
    // values and ready bits
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `PRF_SIZE; i++) begin
                values[i] <= '0;
                ready[i]  <= (i < `ARCH_REGS);   // identity-mapped regs hold 0
            end
        end else if (commit_mis_pred) begin
            // committed values are still in place, only the ready bits move
            ready <= valid_backup;
        end else begin
            if (push) begin
                ready[free_preg] <= 1'b0;
            end
            if (cdb_write) begin
                values[cdb_preg] <= cdb_result;
                ready[cdb_preg]  <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // free list
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `PRF_SIZE; i++) begin
                free_queue[i] <= (i < `PRF_SIZE - `ARCH_REGS) ?
                                 preg_idx_t'(`ARCH_REGS + i) : '0;
            end
            free_head  <= '0;
            free_tail  <= preg_idx_t'(`PRF_SIZE - `ARCH_REGS);
            free_count <= free_cnt_t'(`PRF_SIZE - `ARCH_REGS);
        end else if (commit_mis_pred) begin
            free_queue <= free_queue_backup;
            free_head  <= free_head_backup;
            free_tail  <= free_tail_backup;
            // never more than half full, so tail - head is unambiguous
            free_count <= {1'b0, preg_idx_t'(free_tail_backup - free_head_backup)};
        end else begin
            if (push) begin
                free_queue[free_tail] <= free_preg;
                free_tail             <= free_tail + 1'b1;   // wraps at PRF_SIZE
            end
            if (alloc) begin
                free_head <= free_head + 1'b1;
            end
            case ({push, alloc})
                2'b10:   free_count <= free_count + 1'b1;
                2'b01:   free_count <= free_count - 1'b1;
                default: free_count <= free_count;
            endcase
        end
    end

endmodule

// File: design/retire_map.sv
////////////////////////////////////////
// in-order retire queue with the committed map and free list,
// source of the recovery state on a misprediction
////////////////////////////////////////

`timescale 1ns/1ps

`include "rename_config.svh"

module retire_map
    import rename_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  logic       renamed,
    input  arch_idx_t  dest_arch,
    input  preg_idx_t  dest_preg,
    input  preg_idx_t  prev_preg,
    input  logic       commit_valid,
    input  logic       commit_mis_pred,
    output logic       free_valid,
    output preg_idx_t  free_preg,
    output map_t       committed_map,
    output prf_mask_t  valid_backup,
    output free_list_t free_queue_backup,
    output preg_idx_t  free_head_backup,
    output preg_idx_t  free_tail_backup,
    output logic       queue_full
);

    localparam int RQ_LEN = $clog2(`RETIRE_DEPTH);

    // retire queue payload
    arch_idx_t rq_arch [`RETIRE_DEPTH];
    preg_idx_t rq_dest [`RETIRE_DEPTH];
    preg_idx_t rq_prev [`RETIRE_DEPTH];

    logic [RQ_LEN-1:0] rq_head;
    logic [RQ_LEN-1:0] rq_tail;
    logic [RQ_LEN:0]   rq_count;
    logic              enqueue;
    logic              retire;

    // committed state and its next value
    map_t       cmt_map;
    free_list_t cmt_queue;
    preg_idx_t  cmt_head;
    preg_idx_t  cmt_tail;
    map_t       map_next;
    free_list_t queue_next;
    preg_idx_t  head_next;
    preg_idx_t  tail_next;

    assign queue_full = (rq_count == `RETIRE_DEPTH);
    assign enqueue    = renamed && !commit_mis_pred;
    assign retire     = commit_valid && (rq_count != '0);

    assign free_preg  = rq_prev[rq_head];
    assign free_valid = retire && (free_preg != '0);

    ////////////////////////////////////////
    // committed state after this cycle's commit
    ////////////////////////////////////////

    always_comb begin
        map_next   = cmt_map;
        queue_next = cmt_queue;
        head_next  = cmt_head;
        tail_next  = cmt_tail;
        if (retire) begin
            map_next[rq_arch[rq_head]] = rq_dest[rq_head];
            head_next = cmt_head + 1'b1;   // its allocation is now committed
            if (free_valid) begin
                queue_next[cmt_tail] = free_preg;
                tail_next            = cmt_tail + 1'b1;
            end
        end
    end

    // recovery uses the next state so a commit in the mispredict cycle counts
    assign committed_map     = map_next;
    assign free_queue_backup = queue_next;
    assign free_head_backup  = head_next;
    assign free_tail_backup  = tail_next;

    always_comb begin
        valid_backup = '0;
        for (int i = 0; i < `ARCH_REGS; i++) begin
            valid_backup[map_next[i]] = 1'b1;   // committed pregs have their result
        end
    end

    ////////////////////////////////////////
    // queue control and committed copies
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            rq_head  <= '0;
            rq_tail  <= '0;
            rq_count <= '0;
            for (int i = 0; i < `ARCH_REGS; i++) begin
                cmt_map[i] <= preg_idx_t'(i);
            end
            for (int i = 0; i < `PRF_SIZE; i++) begin
                cmt_queue[i] <= (i < `PRF_SIZE - `ARCH_REGS) ?
                                preg_idx_t'(`ARCH_REGS + i) : '0;
            end
            cmt_head <= '0;
            cmt_tail <= preg_idx_t'(`PRF_SIZE - `ARCH_REGS);
        end else begin
            cmt_map   <= map_next;
            cmt_queue <= queue_next;
            cmt_head  <= head_next;
            cmt_tail  <= tail_next;
            if (commit_mis_pred) begin
                rq_head  <= '0;                   // everything younger is squashed
                rq_tail  <= '0;
                rq_count <= '0;
            end else begin
                if (enqueue) rq_tail <= rq_tail + 1'b1;
                if (retire)  rq_head <= rq_head + 1'b1;
                case ({enqueue, retire})
                    2'b10:   rq_count <= rq_count + 1'b1;
                    2'b01:   rq_count <= rq_count - 1'b1;
                    default: rq_count <= rq_count;
                endcase
            end
        end
    end

    // payload write
    always_ff @(posedge clock) begin
        if (enqueue) begin
            rq_arch[rq_tail] <= dest_arch;
            rq_dest[rq_tail] <= dest_preg;
            rq_prev[rq_tail] <= prev_preg;
        end
    end

endmodule

// File: design/rename_core.sv
////////////////////////////////////////
// rename stage top, map table + register file + retire map
////////////////////////////////////////

`timescale 1ns/1ps

`include "rename_config.svh"

module rename_core
    import rename_pkg::*;
(
    input  logic      clock,
    input  logic      reset,
    // dispatch
    input  logic      dispatch_enable,
    input  logic      dest_valid,
    input  arch_idx_t dest_arch,
    input  arch_idx_t src_a_arch,
    input  arch_idx_t src_b_arch,
    // writeback
    input  logic      cdb_valid,
    input  preg_idx_t cdb_preg,
    input  word_t     cdb_result,
    // commit
    input  logic      commit_valid,
    input  logic      commit_mis_pred,
    // status and operands
    output logic      dispatch_ready,
    output logic      opa_ready,
    output word_t     opa_value,
    output logic      opb_ready,
    output word_t     opb_value
);

    preg_idx_t  opa_preg;
    preg_idx_t  opb_preg;
    preg_idx_t  prev_preg;
    preg_idx_t  new_preg;
    logic       dispatch_fire;
    logic       renamed;
    logic       alloc;
    logic       free_valid;
    preg_idx_t  free_preg;
    map_t       committed_map;
    prf_mask_t  valid_backup;
    free_list_t free_queue_backup;
    preg_idx_t  free_head_backup;
    preg_idx_t  free_tail_backup;
    free_cnt_t  free_count;
    logic       queue_full;

    ////////////////////////////////////////
    // dispatch gating
    ////////////////////////////////////////

    assign dispatch_ready = (free_count != '0) && !queue_full;
    assign dispatch_fire  = dispatch_enable && dispatch_ready;   // else ignored
    assign alloc          = renamed;   // renamed is built from dispatch_fire

    map_table map_table_i (
        .clock           (clock),
        .reset           (reset),
        .dispatch_enable (dispatch_fire),
        .dest_valid      (dest_valid),
        .commit_mis_pred (commit_mis_pred),
        .dest_arch       (dest_arch),
        .src_a_arch      (src_a_arch),
        .src_b_arch      (src_b_arch),
        .new_preg        (new_preg),
        .committed_map   (committed_map),
        .opa_preg        (opa_preg),
        .opb_preg        (opb_preg),
        .prev_preg       (prev_preg),
        .renamed         (renamed)
    );

    prf prf_i (
        .clock             (clock),
        .reset             (reset),
        .opa_preg          (opa_preg),
        .opb_preg          (opb_preg),
        .alloc             (alloc),
        .free_valid        (free_valid),
        .free_preg         (free_preg),
        .cdb_valid         (cdb_valid),
        .cdb_preg          (cdb_preg),
        .cdb_result        (cdb_result),
        .commit_mis_pred   (commit_mis_pred),
        .valid_backup      (valid_backup),
        .free_queue_backup (free_queue_backup),
        .free_head_backup  (free_head_backup),
        .free_tail_backup  (free_tail_backup),
        .new_preg          (new_preg),
        .free_count        (free_count),
        .opa_ready         (opa_ready),
        .opa_value         (opa_value),
        .opb_ready         (opb_ready),
        .opb_value         (opb_value)
    );

    // dest_preg is the free list head taken by this rename
    retire_map retire_map_i (
        .clock             (clock),
        .reset             (reset),
        .renamed           (renamed),
        .dest_arch         (dest_arch),
        .dest_preg         (new_preg),
        .prev_preg         (prev_preg),
        .commit_valid      (commit_valid),
        .commit_mis_pred   (commit_mis_pred),
        .free_valid        (free_valid),
        .free_preg         (free_preg),
        .committed_map     (committed_map),
        .valid_backup      (valid_backup),
        .free_queue_backup (free_queue_backup),
        .free_head_backup  (free_head_backup),
        .free_tail_backup  (free_tail_backup),
        .queue_full        (queue_full)
    );

endmodule

// File: bench/rename_core_assert.sv
////////////////////////////////////////
// concurrent checks bound into the rename stage top
////////////////////////////////////////

`timescale 1ns/1ps

`include "rename_config.svh"

module rename_core_assert
    import rename_pkg::*;
(
    input logic      clock,
    input logic      reset,
    input logic      commit_valid,
    input logic      commit_mis_pred,
    input logic      free_valid,
    input free_cnt_t free_count,
    input logic      queue_full,
    input logic      cdb_valid,
    input preg_idx_t cdb_preg,
    input arch_idx_t src_a_arch,
    input word_t     opa_value
);

    // an empty free list gives out nothing until a register comes back
    assert property (@(posedge clock) disable iff (reset)
        ((free_count == '0) && !free_valid && !commit_mis_pred) |=> (free_count == '0))
        else $error("register allocated while the free list is empty");

    // a full retire queue takes no dispatch until a commit or recovery
    assert property (@(posedge clock) disable iff (reset)
        (queue_full && !commit_valid && !commit_mis_pred) |=> queue_full)
        else $error("dispatch accepted with a full retire queue");

    // hard zero survives a broadcast aimed at preg 0
    assert property (@(posedge clock) disable iff (reset)
        (cdb_valid && (cdb_preg == '0) && (src_a_arch == '0)) |-> (opa_value == '0))
        else $error("broadcast to register 0 changed the value of arch register 0");

endmodule

bind rename_core rename_core_assert rename_core_assert_i (.*);

// File: bench/rename_core_tb.sv
////////////////////////////////////////
// rename stage testbench, plays decode, execute and reorder buffer
// from a step table and checks both operand ports every cycle
////////////////////////////////////////

`timescale 1ns/1ps

`include "rename_config.svh"

module rename_core_tb
    import rename_pkg::*;
();

    localparam int NB = -2;   // no broadcast
    localparam int ZP = -1;   // broadcast aimed at preg 0

    // one cycle of stimulus, cs picks the retire queue entry to broadcast
    typedef struct {
        bit    de, cm, mp;
        int    dst, sa, sb, cs;
        word_t cr;
        bit    dr, ar, br;
        word_t av, bv;
    } step_t;

    logic      clock;
    logic      reset;
    logic      dispatch_enable;
    logic      dest_valid;
    arch_idx_t dest_arch;
    arch_idx_t src_a_arch;
    arch_idx_t src_b_arch;
    logic      cdb_valid;
    preg_idx_t cdb_preg;
    word_t     cdb_result;
    logic      commit_valid;
    logic      commit_mis_pred;
    logic      dispatch_ready;
    logic      opa_ready;
    word_t     opa_value;
    logic      opb_ready;
    word_t     opb_value;

    step_t steps[$];
    int    errors;
    int    timeouts;
    int    waited;

    // reference rename state
    int spec_map [`ARCH_REGS];
    int cmt_map  [`ARCH_REGS];
    int spec_free[$];
    int cmt_free [$];
    int rob_arch [$];
    int rob_new  [$];
    int rob_prev [$];

    rename_core rename_core_i (.*);

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        assert (got === exp) else begin
            errors++;
            $display("MISMATCH time=%0t %s expected=%h got=%h", $time, name, exp, got);
        end
    endtask

    task automatic add_step(input bit de, input int dst, input int sa, input int sb,
                            input int cs, input word_t cr, input bit cm, input bit mp,
                            input bit dr, input bit ar, input word_t av,
                            input bit br, input word_t bv);
        step_t s;
        s = '{de: de, cm: cm, mp: mp, dst: dst, sa: sa, sb: sb, cs: cs, cr: cr,
              dr: dr, ar: ar, br: br, av: av, bv: bv};
        steps.push_back(s);
    endtask

    task automatic apply_step(input step_t s);
        int  a;
        int  n;
        int  p;
        bit  can_dispatch;
        @(negedge clock);
        dispatch_enable = s.de;
        dest_valid      = s.de;
        dest_arch       = arch_idx_t'(s.dst);
        src_a_arch      = arch_idx_t'(s.sa);
        src_b_arch      = arch_idx_t'(s.sb);
        cdb_valid       = (s.cs != NB);
        cdb_preg        = (s.cs >= 0) ? preg_idx_t'(rob_new[s.cs]) : '0;
        cdb_result      = s.cr;
        commit_valid    = s.cm;
        commit_mis_pred = s.mp;
        #2;
        check_value("dispatch_ready", s.dr, dispatch_ready);
        check_value("opa_ready", s.ar, opa_ready);
        check_value("opb_ready", s.br, opb_ready);
        if (s.ar) check_value("opa_value", s.av, opa_value);   // stale data when not ready
        if (s.br) check_value("opb_value", s.bv, opb_value);

        // model the edge, commit retires before any recovery
        can_dispatch = (spec_free.size() != 0) && (rob_new.size() < `RETIRE_DEPTH);
        if (s.cm) begin
            a = rob_arch.pop_front();
            n = rob_new.pop_front();
            p = rob_prev.pop_front();
            cmt_map[a] = n;
            void'(cmt_free.pop_front());
            if (p != 0) begin
                spec_free.push_back(p);
                cmt_free.push_back(p);
            end
        end
        if (s.mp) begin
            spec_map  = cmt_map;
            spec_free = cmt_free;
            rob_arch.delete();
            rob_new.delete();
            rob_prev.delete();
        end else if (s.de && can_dispatch && s.dst != 0) begin
            n = spec_free.pop_front();
            rob_arch.push_back(s.dst);
            rob_new.push_back(n);
            rob_prev.push_back(spec_map[s.dst]);
            spec_map[s.dst] = n;
        end
    endtask

    initial begin
        reset = 1'b1;
        dispatch_enable = 1'b0;
        dest_valid = 1'b0;
        dest_arch = '0;
        src_a_arch = '0;
        src_b_arch = '0;
        cdb_valid = 1'b0;
        cdb_preg = '0;
        cdb_result = '0;
        commit_valid = 1'b0;
        commit_mis_pred = 1'b0;
        errors = 0;
        timeouts = 0;
        for (int i = 0; i < `ARCH_REGS; i++) begin
            spec_map[i] = i;
            cmt_map[i]  = i;
        end
        for (int i = `ARCH_REGS; i < `PRF_SIZE; i++) begin
            spec_free.push_back(i);
            cmt_free.push_back(i);
        end

        ////////////////////////////////////////
        // de dst sa sb cs cr cm mp | dr ar av br bv
        ////////////////////////////////////////
        add_step(0, 0, 1, 2, NB, 'h0, 0, 0, 1, 1, 'h0, 1, 'h0);   // reset state
        add_step(0, 0, 3, 7, NB, 'h0, 0, 0, 1, 1, 'h0, 1, 'h0);
        add_step(1, 1, 1, 2, NB, 'h0, 0, 0, 1, 1, 'h0, 1, 'h0);
        add_step(0, 0, 1, 2, NB, 'h0, 0, 0, 1, 0, 'h0, 1, 'h0);
        add_step(0, 0, 1, 1, 0, 'h1111_0001, 0, 0, 1, 1, 'h1111_0001, 1, 'h1111_0001);
        add_step(0, 0, 1, 0, NB, 'h0, 0, 0, 1, 1, 'h1111_0001, 1, 'h0);
        add_step(1, 0, 0, 1, ZP, 'hdead_beef, 0, 0, 1, 1, 'h0, 1, 'h1111_0001);
        add_step(0, 0, 0, 0, NB, 'h0, 0, 0, 1, 1, 'h0, 1, 'h0);
        add_step(0, 0, 1, 2, NB, 'h0, 1, 0, 1, 1, 'h1111_0001, 1, 'h0);
        // fill the retire queue and the free list
        add_step(1, 2, 1, 2, NB, 'h0, 0, 0, 1, 1, 'h1111_0001, 1, 'h0);
        add_step(1, 3, 2, 3, NB, 'h0, 0, 0, 1, 0, 'h0, 1, 'h0);
        add_step(1, 4, 4, 1, NB, 'h0, 0, 0, 1, 1, 'h0, 1, 'h1111_0001);
        add_step(1, 5, 5, 5, NB, 'h0, 0, 0, 1, 1, 'h0, 1, 'h0);
        add_step(1, 6, 6, 4, NB, 'h0, 0, 0, 1, 1, 'h0, 0, 'h0);
        add_step(1, 7, 7, 0, NB, 'h0, 0, 0, 1, 1, 'h0, 1, 'h0);
        add_step(1, 1, 1, 7, NB, 'h0, 0, 0, 1, 1, 'h1111_0001, 0, 'h0);
        add_step(1, 2, 2, 3, NB, 'h0, 0, 0, 1, 0, 'h0, 0, 'h0);
        add_step(1, 3, 2, 1, NB, 'h0, 0, 0, 0, 0, 'h0, 0, 'h0);   // ignored
        add_step(0, 0, 3, 2, 1, 'h3333_0003, 0, 0, 0, 1, 'h3333_0003, 0, 'h0);
        add_step(0, 0, 3, 2, 0, 'h2222_0002, 0, 0, 0, 1, 'h3333_0003, 0, 'h0);
        add_step(0, 0, 2, 3, NB, 'h0, 1, 0, 0, 0, 'h0, 1, 'h3333_0003);
        add_step(0, 0, 3, 2, NB, 'h0, 0, 0, 1, 1, 'h3333_0003, 0, 'h0);
        add_step(0, 0, 3, 4, NB, 'h0, 1, 0, 1, 1, 'h3333_0003, 0, 'h0);
        add_step(0, 0, 3, 1, NB, 'h0, 0, 0, 1, 1, 'h3333_0003, 0, 'h0);
        add_step(0, 0, 4, 3, 0, 'h4444_0004, 0, 0, 1, 1, 'h4444_0004, 1, 'h3333_0003);
        add_step(0, 0, 1, 4, 4, 'h5555_0001, 0, 0, 1, 1, 'h5555_0001, 1, 'h4444_0004);
        add_step(0, 0, 4, 1, NB, 'h0, 1, 0, 1, 1, 'h4444_0004, 1, 'h5555_0001);
        // recovery to the committed state
        add_step(0, 0, 1, 2, NB, 'h0, 0, 1, 1, 1, 'h5555_0001, 0, 'h0);
        add_step(0, 0, 1, 2, NB, 'h0, 0, 0, 1, 1, 'h1111_0001, 1, 'h2222_0002);
        add_step(0, 0, 4, 3, NB, 'h0, 0, 0, 1, 1, 'h4444_0004, 1, 'h3333_0003);
        add_step(1, 5, 5, 1, NB, 'h0, 0, 0, 1, 1, 'h0, 1, 'h1111_0001);
        add_step(1, 6, 5, 6, NB, 'h0, 0, 0, 1, 0, 'h0, 1, 'h0);
        add_step(1, 7, 7, 2, NB, 'h0, 0, 0, 1, 1, 'h0, 1, 'h2222_0002);
        add_step(1, 1, 1, 4, NB, 'h0, 0, 0, 1, 1, 'h1111_0001, 1, 'h4444_0004);
        add_step(1, 2, 1, 3, NB, 'h0, 0, 0, 1, 0, 'h0, 1, 'h3333_0003);
        add_step(1, 3, 2, 3, NB, 'h0, 0, 0, 1, 0, 'h0, 1, 'h3333_0003);
        add_step(1, 4, 4, 0, NB, 'h0, 0, 0, 1, 1, 'h4444_0004, 1, 'h0);
        add_step(1, 5, 4, 5, NB, 'h0, 0, 0, 1, 0, 'h0, 0, 'h0);
        add_step(0, 0, 5, 1, NB, 'h0, 0, 0, 0, 0, 'h0, 0, 'h0);   // full again

        repeat (5) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        waited = 0;
        while (!dispatch_ready && waited < 20) begin
            @(negedge clock);
            waited++;
        end
        if (!dispatch_ready) begin
            timeouts++;
            $display("dispatch_ready never came up after reset");
        end else begin
            foreach (steps[i]) apply_step(steps[i]);
        end

        @(negedge clock);
        $display("checks done: %0d mismatches, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: project.f
+incdir+design
design/rename_pkg.sv
design/map_table.sv
design/prf.sv
design/retire_map.sv
design/rename_core.sv
bench/rename_core_assert.sv
bench/rename_core_tb.sv
